/* hdl/csrTrapState.sv */
////////////////////////////////////////////////////////////
// Privileged state consumer
// Applies trap records to the CSRs and offers the redirect
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module csrTrapState import trapPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       headValid,
  input  trapRecordT head,
  input  logic       redirectReady,
  input  csrWriteT   csrWrite,
  input  csrAddrT    csrRdAddr,
  output logic       pop,
  output logic       flushDone,
  output logic       redirectValid,
  output redirectT   redirect,
  output trapStateT  state,
  output wordT       csrRdData
);

  privT priv;
  wordT mstatus, medeleg, mtvec, stvec;
  irqT  mideleg, mie;
  wordT mepc, mcause, mtval;
  wordT sepc, scause, stval;
  wordT minstret;
  logic isCtrl;

  // Traps and returns need the fetch side to take them
  assign isCtrl        = (head.kind == KindTrap) || (head.kind == KindReturn);
  assign redirectValid = headValid && isCtrl;
  assign redirect.pc   = head.nextPc;
  assign redirect.priv = head.toPriv;
  assign pop           = headValid && (!isCtrl || redirectReady);
  assign flushDone     = pop && isCtrl;

  // Register view for the producer
  assign state.priv    = priv;
  assign state.mstatus = mstatus;
  assign state.medeleg = medeleg;
  assign state.mideleg = mideleg;
  assign state.mie     = mie;
  assign state.mtvec   = mtvec;
  assign state.stvec   = stvec;
  assign state.mepc    = mepc;
  assign state.sepc    = sepc;

  ////////////////////////////////////////////////////////////
  // CSR update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      priv     <= PrivM;
      mstatus  <= '0;
      medeleg  <= '0;
      mideleg  <= '0;
      mie      <= '0;
      mtvec    <= '0;
      stvec    <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
      sepc     <= '0;
      scause   <= '0;
      stval    <= '0;
      minstret <= '0;
    end else begin
      // Outside port, used only with the queue empty
      if (csrWrite.en) begin
        case (csrWrite.addr)
          Mstatus:  mstatus  <= csrWrite.data;
          Medeleg:  medeleg  <= csrWrite.data;
          Mideleg:  mideleg  <= csrWrite.data[11:0];
          Mie:      mie      <= csrWrite.data[11:0];
          Mtvec:    mtvec    <= csrWrite.data;
          Mepc:     mepc     <= csrWrite.data;
          Mcause:   mcause   <= csrWrite.data;
          Mtval:    mtval    <= csrWrite.data;
          Stvec:    stvec    <= csrWrite.data;
          Sepc:     sepc     <= csrWrite.data;
          Scause:   scause   <= csrWrite.data;
          Stval:    stval    <= csrWrite.data;
          Minstret: minstret <= csrWrite.data;
          default:  ;
        endcase
      end
      if (pop) begin
        case (head.kind)
          KindNormal: minstret <= minstret + 1'b1;
          KindTrap: begin
            if (head.toPriv == PrivM) begin
              mepc                <= head.epc;
              mcause              <= head.cause;
              mtval               <= head.tval;
              mstatus[StatusMpie] <= mstatus[StatusMie];
              mstatus[StatusMie]  <= 1'b0;
              mstatus[StatusMppHi:StatusMppLo] <= priv;
            end else begin
              sepc                <= head.epc;
              scause              <= head.cause;
              stval               <= head.tval;
              mstatus[StatusSpie] <= mstatus[StatusSie];
              mstatus[StatusSie]  <= 1'b0;
              // SPP only holds U or S
              mstatus[StatusSpp]  <= priv[0];
            end
            priv <= head.toPriv;
          end
          KindReturn: begin
            if (head.retKind == RetMret) begin
              priv                <= mstatus[StatusMppHi:StatusMppLo];
              mstatus[StatusMie]  <= mstatus[StatusMpie];
              mstatus[StatusMpie] <= 1'b1;
            end else begin
              priv                <= {1'b0, mstatus[StatusSpp]};
              mstatus[StatusSie]  <= mstatus[StatusSpie];
              mstatus[StatusSpie] <= 1'b1;
            end
          end
          // Squashed records leave no trace
          default: ;
        endcase
      end
    end
  end

  // Combinational read port
  always_comb begin
    case (csrRdAddr)
      Mstatus:  csrRdData = mstatus;
      Medeleg:  csrRdData = medeleg;
      Mideleg:  csrRdData = wordT'(mideleg);
      Mie:      csrRdData = wordT'(mie);
      Mtvec:    csrRdData = mtvec;
      Mepc:     csrRdData = mepc;
      Mcause:   csrRdData = mcause;
      Mtval:    csrRdData = mtval;
      Stvec:    csrRdData = stvec;
      Sepc:     csrRdData = sepc;
      Scause:   csrRdData = scause;
      Stval:    csrRdData = stval;
      Minstret: csrRdData = minstret;
      default:  csrRdData = '0;
    endcase
  end

endmodule

/* hdl/trapPkg.sv */
////////////////////////////////////////////////////////////
// Trap path package
// Widths, CSR numbers, cause codes and the records that
// travel between the trap producer, its queue and the CSRs
////////////////////////////////////////////////////////////

package trapPkg;

  // Machine word and queue sizing
  localparam int Xlen       = 32;
  localparam int QueueDepth = 4;
  localparam int QueuePtrW  = $clog2(QueueDepth);

  // Vector types with a meaning
  typedef logic [Xlen-1:0] wordT;
  typedef logic [1:0]      privT;
  typedef logic [11:0]     csrAddrT;
  typedef logic [11:0]     irqT;
  typedef logic [2:0]      creditT;
  typedef logic [1:0]      kindT;

  // Privilege levels
  localparam privT PrivU = 2'd0;
  localparam privT PrivS = 2'd1;
  localparam privT PrivM = 2'd3;

  // CSR numbers
  localparam csrAddrT Mstatus  = 12'h300;
  localparam csrAddrT Medeleg  = 12'h302;
  localparam csrAddrT Mideleg  = 12'h303;
  localparam csrAddrT Mie      = 12'h304;
  localparam csrAddrT Mtvec    = 12'h305;
  localparam csrAddrT Mepc     = 12'h341;
  localparam csrAddrT Mcause   = 12'h342;
  localparam csrAddrT Mtval    = 12'h343;
  localparam csrAddrT Stvec    = 12'h105;
  localparam csrAddrT Sepc     = 12'h141;
  localparam csrAddrT Scause   = 12'h142;
  localparam csrAddrT Stval    = 12'h143;
  localparam csrAddrT Minstret = 12'hB02;

  // Exception causes, privileged spec table
  localparam wordT CauseInstrMisaligned = 32'd0;
  localparam wordT CauseInstrAccess     = 32'd1;
  localparam wordT CauseIllegalInstr    = 32'd2;
  localparam wordT CauseBreakpoint      = 32'd3;
  localparam wordT CauseLoadMisaligned  = 32'd4;
  localparam wordT CauseLoadAccess      = 32'd5;
  localparam wordT CauseStoreMisaligned = 32'd6;
  localparam wordT CauseStoreAccess     = 32'd7;
  localparam wordT CauseEcallU          = 32'd8;
  localparam wordT CauseInstrPage       = 32'd12;
  localparam wordT CauseLoadPage        = 32'd13;
  localparam wordT CauseStorePage       = 32'd15;
  // Interrupt flag in mcause/scause
  localparam wordT CauseIntFlag         = 32'h8000_0000;

  // Interrupt bit positions in mip/mie
  localparam int IrqMei = 11;
  localparam int IrqMsi = 3;
  localparam int IrqMti = 7;
  localparam int IrqSei = 9;
  localparam int IrqSsi = 1;
  localparam int IrqSti = 5;

  // mstatus fields
  localparam int StatusSie   = 1;
  localparam int StatusMie   = 3;
  localparam int StatusSpie  = 5;
  localparam int StatusMpie  = 7;
  localparam int StatusSpp   = 8;
  localparam int StatusMppLo = 11;
  localparam int StatusMppHi = 12;

  // Record kinds and return flavours
  localparam kindT KindNormal   = 2'd0;
  localparam kindT KindTrap     = 2'd1;
  localparam kindT KindReturn   = 2'd2;
  localparam kindT KindSquashed = 2'd3;
  localparam logic RetMret      = 1'b0;
  localparam logic RetSret      = 1'b1;

  typedef struct packed {
    logic instrMisaligned;
    logic instrAccess;
    logic illegalInstr;
    logic breakpoint;
    logic loadMisaligned;
    logic loadAccess;
    logic storeMisaligned;
    logic storeAccess;
    logic ecall;
    logic instrPage;
    logic loadPage;
    logic storePage;
  } faultFlagsT;

  typedef struct packed {
    wordT       pc;
    wordT       instr;
    wordT       instrMisalignedAdr;
    wordT       dataAdr;
    faultFlagsT faults;
    logic       mret;
    logic       sret;
  } retireEventT;

  typedef struct packed {
    kindT kind;
    privT toPriv;
    logic retKind;
    wordT nextPc;
    wordT cause;
    wordT tval;
    wordT epc;
  } trapRecordT;

  // CSR view the producer needs for classification
  typedef struct packed {
    privT priv;
    wordT mstatus;
    wordT medeleg;
    irqT  mideleg;
    irqT  mie;
    wordT mtvec;
    wordT stvec;
    wordT mepc;
    wordT sepc;
  } trapStateT;

  typedef struct packed {
    logic    en;
    csrAddrT addr;
    wordT    data;
  } csrWriteT;

  typedef struct packed {
    wordT pc;
    privT priv;
  } redirectT;

endpackage

/* hdl/trapQueue.sv */
////////////////////////////////////////////////////////////
// Trap record queue
// Credit-managed FIFO, one credit back per pop
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module trapQueue import trapPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       recValid,
  input  trapRecordT rec,
  input  logic       pop,
  output logic       headValid,
  output trapRecordT head,
  output logic       creditReturn
);

  trapRecordT            mem [QueueDepth];
  logic [QueuePtrW-1:0]  wrPtr, rdPtr;
  creditT                count;
  logic                  doPop;

  // Producer holds a credit per write, so no full check
  assign doPop     = pop && headValid;
  assign headValid = (count != '0);
  assign head      = mem[rdPtr];

  // Storage
  always_ff @(posedge clk) begin
    if (recValid) begin
      mem[wrPtr] <= rec;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr        <= '0;
      rdPtr        <= '0;
      count        <= '0;
      creditReturn <= 1'b0;
    end else begin
      if (recValid) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      count        <= count + creditT'(recValid) - creditT'(doPop);
      // One-cycle pulse after every pop
      creditReturn <= doPop;
    end
  end

endmodule

/* hdl/trapTop.sv */
////////////////////////////////////////////////////////////
// Trap path top level
// Producer, credit queue and CSR consumer in a chain
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module trapTop import trapPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        retireValid,
  input  retireEventT retire,
  input  irqT         irqLines,
  input  logic        redirectReady,
  input  csrWriteT    csrWrite,
  input  csrAddrT     csrRdAddr,
  output logic        retireReady,
  output logic        redirectValid,
  output redirectT    redirect,
  output wordT        csrRdData
);

  // Producer to queue
  logic       recValid;
  trapRecordT rec;
  logic       creditReturn;

  // Queue to consumer
  logic       headValid;
  trapRecordT head;
  logic       pop;

  // Consumer back to producer
  trapStateT  state;
  logic       flushDone;

  trapUnit trapUnit0 (
    .clk          (clk),
    .reset        (reset),
    .retireValid  (retireValid),
    .retire       (retire),
    .irqLines     (irqLines),
    .state        (state),
    .creditReturn (creditReturn),
    .flushDone    (flushDone),
    .retireReady  (retireReady),
    .recValid     (recValid),
    .rec          (rec)
  );

  trapQueue trapQueue0 (
    .clk          (clk),
    .reset        (reset),
    .recValid     (recValid),
    .rec          (rec),
    .pop          (pop),
    .headValid    (headValid),
    .head         (head),
    .creditReturn (creditReturn)
  );

  csrTrapState csrTrapState0 (
    .clk           (clk),
    .reset         (reset),
    .headValid     (headValid),
    .head          (head),
    .redirectReady (redirectReady),
    .csrWrite      (csrWrite),
    .csrRdAddr     (csrRdAddr),
    .pop           (pop),
    .flushDone     (flushDone),
    .redirectValid (redirectValid),
    .redirect      (redirect),
    .state         (state),
    .csrRdData     (csrRdData)
  );

endmodule

/* hdl/trapUnit.sv */
////////////////////////////////////////////////////////////
// Trap producer
// Classifies each retire, ranks causes, builds trap records
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module trapUnit import trapPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        retireValid,
  input  retireEventT retire,
  input  irqT         irqLines,
  input  trapStateT   state,
  input  logic        creditReturn,
  input  logic        flushDone,
  output logic        retireReady,
  output logic        recValid,
  output trapRecordT  rec
);

  typedef enum logic {Run, Squash} squashStateT;

  squashStateT squashState;
  creditT      credits;
  logic        accept;
  logic        mIntEn, sIntEn;
  irqT         pendInts;
  logic        isInt, isExc, isTrap, isRet;
  logic        delegBit;
  faultFlagsT  f;
  wordT        cause, tval, tvec, vector;
  privT        toPriv;
  trapRecordT  nextRec;

  // Credit counter, one per free queue slot
  assign retireReady = (credits != '0);
  assign accept      = retireValid && retireReady;

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= creditT'(QueueDepth);
    end else begin
      // Send and return in one cycle cancel out
      credits <= credits - creditT'(accept) + creditT'(creditReturn);
    end
  end

  ////////////////////////////////////////////////////////////
  // Interrupt and exception classification
  ////////////////////////////////////////////////////////////

  // Global enables follow the current privilege
  assign mIntEn = (state.priv != PrivM) || state.mstatus[StatusMie];
  assign sIntEn = (state.priv == PrivU) ||
                  ((state.priv == PrivS) && state.mstatus[StatusSie]);

  // M-level lines are the undelegated ones
  assign pendInts = (irqLines & state.mie & ~state.mideleg & {12{mIntEn}}) |
                    (irqLines & state.mie & state.mideleg & {12{sIntEn}});

  assign f      = retire.faults;
  assign isInt  = |pendInts;
  assign isExc  = |f;
  assign isTrap = isInt || isExc;
  assign isRet  = retire.mret || retire.sret;

  // Interrupts first, then exceptions in spec order
  always_comb begin
    if      (pendInts[IrqMei])  cause = CauseIntFlag | wordT'(IrqMei);
    else if (pendInts[IrqMsi])  cause = CauseIntFlag | wordT'(IrqMsi);
    else if (pendInts[IrqMti])  cause = CauseIntFlag | wordT'(IrqMti);
    else if (pendInts[IrqSei])  cause = CauseIntFlag | wordT'(IrqSei);
    else if (pendInts[IrqSsi])  cause = CauseIntFlag | wordT'(IrqSsi);
    else if (pendInts[IrqSti])  cause = CauseIntFlag | wordT'(IrqSti);
    else if (f.instrPage)       cause = CauseInstrPage;
    else if (f.instrAccess)     cause = CauseInstrAccess;
    else if (f.instrMisaligned) cause = CauseInstrMisaligned;
    else if (f.illegalInstr)    cause = CauseIllegalInstr;
    else if (f.breakpoint)      cause = CauseBreakpoint;
    // Ecall code tracks the trapping privilege
    else if (f.ecall)           cause = CauseEcallU + wordT'(state.priv);
    else if (f.loadMisaligned)  cause = CauseLoadMisaligned;
    else if (f.storeMisaligned) cause = CauseStoreMisaligned;
    else if (f.loadPage)        cause = CauseLoadPage;
    else if (f.storePage)       cause = CauseStorePage;
    else if (f.loadAccess)      cause = CauseLoadAccess;
    else if (f.storeAccess)     cause = CauseStoreAccess;
    else                        cause = '0;
  end

  // Delegation only applies below M
  assign delegBit = isInt ? state.mideleg[cause[3:0]] : state.medeleg[cause[4:0]];
  assign toPriv   = ((state.priv != PrivM) && delegBit) ? PrivS : PrivM;

  // Vectored mode adds 4 x code for interrupts only
  assign tvec = (toPriv == PrivS) ? state.stvec : state.mtvec;
  always_comb begin
    vector = {tvec[Xlen-1:2], 2'b00};
    if ((tvec[1:0] == 2'b01) && isInt) begin
      vector = vector + {cause[Xlen-3:0], 2'b00};
    end
  end

  // Trap value for the cause that won
  always_comb begin
    if (isInt || !isExc) begin
      tval = '0;
    end else begin
      case (cause)
        CauseInstrMisaligned:                 tval = retire.instrMisalignedAdr;
        CauseLoadMisaligned, CauseStoreMisaligned,
        CauseLoadPage, CauseStorePage:        tval = retire.dataAdr;
        CauseBreakpoint, CauseInstrPage:      tval = retire.pc;
        CauseIllegalInstr:                    tval = retire.instr;
        default:                              tval = '0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Record build and squash FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    nextRec     = '0;
    nextRec.epc = retire.pc;
    if (squashState == Squash) begin
      nextRec.kind = KindSquashed;
    end else if (isTrap) begin
      nextRec.kind   = KindTrap;
      nextRec.toPriv = toPriv;
      nextRec.nextPc = vector;
      nextRec.cause  = cause;
      nextRec.tval   = tval;
    end else if (isRet) begin
      nextRec.kind    = KindReturn;
      nextRec.retKind = retire.mret ? RetMret : RetSret;
      nextRec.nextPc  = retire.mret ? state.mepc : state.sepc;
      // Destination privilege from the saved previous mode
      nextRec.toPriv  = retire.mret ? state.mstatus[StatusMppHi:StatusMppLo]
                                    : {1'b0, state.mstatus[StatusSpp]};
    end else begin
      nextRec.kind = KindNormal;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      squashState <= Run;
      recValid    <= 1'b0;
    end else begin
      recValid <= accept;
      case (squashState)
        Run:     if (accept && (isTrap || isRet)) squashState <= Squash;
        // Hold until the control record has been applied
        Squash:  if (flushDone) squashState <= Run;
        default: squashState <= Run;
      endcase
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (accept) begin
      rec <= nextRec;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the trap path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module trapTb -f tb.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/VtrapTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
  exit 0
fi
exit 1

/* tb.f */
hdl/trapPkg.sv
hdl/trapUnit.sv
hdl/trapQueue.sv
hdl/csrTrapState.sv
hdl/trapTop.sv
tests/trapTb.sv

/* tests/trapTb.sv */
////////////////////////////////////////////////////////////
// Trap path testbench
// Directed tests for priority, vectoring, delegation, credits
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module trapTb import trapPkg::*; ();

  localparam int CycleLimit   = 2000;
  localparam int ReadyWait    = 50;
  localparam int RedirectWait = 20;

  logic        clk;
  logic        reset;
  logic        retireValid;
  retireEventT retire;
  irqT         irqLines;
  logic        redirectReady;
  csrWriteT    csrWrite;
  csrAddrT     csrRdAddr;
  logic        retireReady;
  logic        redirectValid;
  redirectT    redirect;
  wordT        csrRdData;

  int          cycles = 0;
  // Instructions retired as normal so far
  wordT        expInstret;

  trapTop dut0 (
    .clk           (clk),
    .reset         (reset),
    .retireValid   (retireValid),
    .retire        (retire),
    .irqLines      (irqLines),
    .redirectReady (redirectReady),
    .csrWrite      (csrWrite),
    .csrRdAddr     (csrRdAddr),
    .retireReady   (retireReady),
    .redirectValid (redirectValid),
    .redirect      (redirect),
    .csrRdData     (csrRdData)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CycleLimit) begin
      stopOnError($sformatf("Timeout, the run went past %0d cycles", CycleLimit));
    end
  end

  ////////////////////////////////////////////////////////////
  // Error path and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic stopOnError(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic checkWord(input string name, input wordT got, input wordT exp);
    if (got !== exp) begin
      stopOnError($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkPriv(input string name, input privT got, input privT exp);
    if (got !== exp) begin
      stopOnError($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkRedirect(input string name, input redirectT got, input redirectT exp);
    if (got !== exp) begin
      stopOnError($sformatf("FAILED %s: got pc 0x%h priv 0x%h, expected pc 0x%h priv 0x%h",
                            name, got.pc, got.priv, exp.pc, exp.priv));
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stopOnError($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Driver tasks
  ////////////////////////////////////////////////////////////

  function automatic wordT randWord();
    return $urandom();
  endfunction

  // Clean retire with random pc and addresses
  function automatic retireEventT newEvent();
    retireEventT ev;
    ev                    = '0;
    ev.pc                 = randWord() & 32'hFFFF_FFFC;
    ev.instr              = randWord();
    ev.instrMisalignedAdr = randWord();
    ev.dataAdr            = randWord();
    return ev;
  endfunction

  task automatic csrWr(input csrAddrT addr, input wordT data);
    @(negedge clk);
    csrWrite.en   = 1'b1;
    csrWrite.addr = addr;
    csrWrite.data = data;
    @(negedge clk);
    csrWrite.en   = 1'b0;
  endtask

  task automatic csrRd(input csrAddrT addr, output wordT data);
    @(negedge clk);
    csrRdAddr = addr;
    #1;
    data = csrRdData;
  endtask

  // Hold valid until retireReady is seen, then one transfer edge
  task automatic retireOne(input retireEventT ev, input irqT irq);
    int waited;
    waited = 0;
    @(negedge clk);
    retire      = ev;
    irqLines    = irq;
    retireValid = 1'b1;
    while (!retireReady) begin
      if (waited >= ReadyWait) begin
        stopOnError("retireReady stayed low, the retire was never accepted");
      end else begin
        waited++;
        @(negedge clk);
      end
    end
    @(posedge clk);
    @(negedge clk);
    retireValid = 1'b0;
  endtask

  // Bounded wait for the redirect, then take it for one edge
  task automatic waitRedirect(output redirectT got);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!redirectValid) begin
      if (waited >= RedirectWait) begin
        stopOnError("No redirect was offered after a trap or return retire");
      end else begin
        waited++;
        @(negedge clk);
      end
    end
    got           = redirect;
    redirectReady = 1'b1;
    @(negedge clk);
    redirectReady = 1'b0;
  endtask

  // Record reaches the head two edges after acceptance
  task automatic settle(input int n);
    repeat (n) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic resetState();
    wordT v;
    checkBit("retireReady", retireReady, 1'b1);
    checkBit("redirectValid", redirectValid, 1'b0);
    csrRd(Mcause, v);
    checkWord("mcause", v, 32'h0);
    csrRd(Mepc, v);
    checkWord("mepc", v, 32'h0);
    csrRd(Minstret, v);
    checkWord("minstret", v, 32'h0);
    // Nothing retired, nothing offered
    repeat (5) begin
      @(negedge clk);
      checkBit("redirectValid", redirectValid, 1'b0);
    end
  endtask

  task automatic exceptionPriority();
    retireEventT ev;
    redirectT    got;
    wordT        base;
    wordT        v;
    base = randWord() & 32'hFFFF_FFC0;
    csrWr(Mtvec, base);
    csrWr(Mstatus, 32'h0000_0008);
    // Illegal instruction outranks load misaligned
    ev                     = newEvent();
    ev.faults.illegalInstr = 1'b1;
    ev.faults.loadMisaligned = 1'b1;
    retireOne(ev, '0);
    waitRedirect(got);
    checkRedirect("redirect", got, '{pc: base, priv: 2'd3});
    settle(2);
    csrRd(Mcause, v);
    checkWord("mcause", v, 32'd2);
    csrRd(Mtval, v);
    checkWord("mtval", v, ev.instr);
    csrRd(Mepc, v);
    checkWord("mepc", v, ev.pc);
    csrRd(Mstatus, v);
    checkBit("mstatus.MIE", v[3], 1'b0);
    checkBit("mstatus.MPIE", v[7], 1'b1);
    checkPriv("mstatus.MPP", v[12:11], 2'd3);
    // Breakpoint reports the pc
    ev                   = newEvent();
    ev.faults.breakpoint = 1'b1;
    retireOne(ev, '0);
    waitRedirect(got);
    checkRedirect("redirect", got, '{pc: base, priv: 2'd3});
    settle(2);
    csrRd(Mcause, v);
    checkWord("mcause", v, 32'd3);
    csrRd(Mtval, v);
    checkWord("mtval", v, ev.pc);
  endtask

  task automatic interruptVectoring();
    retireEventT ev;
    redirectT    got;
    wordT        vbase;
    wordT        retPc;
    wordT        v;
    vbase = randWord() & 32'hFFFF_FFC0;
    retPc = randWord() & 32'hFFFF_FFFC;
    // Drop to S through mret
    csrWr(Mstatus, 32'h0000_0800);
    csrWr(Mepc, retPc);
    ev      = newEvent();
    ev.mret = 1'b1;
    retireOne(ev, '0);
    waitRedirect(got);
    checkRedirect("redirect", got, '{pc: retPc, priv: 2'd1});
    csrWr(Mtvec, vbase | 32'h1);
    csrWr(Mie, 32'h0000_0080);
    // Timer interrupt beats the illegal instruction
    ev                     = newEvent();
    ev.faults.illegalInstr = 1'b1;
    retireOne(ev, 12'h080);
    waitRedirect(got);
    checkRedirect("redirect", got, '{pc: vbase + 32'd28, priv: 2'd3});
    settle(2);
    csrRd(Mcause, v);
    checkWord("mcause", v, 32'h8000_0007);
    csrRd(Mepc, v);
    checkWord("mepc", v, ev.pc);
    csrRd(Mtval, v);
    checkWord("mtval", v, 32'h0);
    csrRd(Mstatus, v);
    checkPriv("mstatus.MPP", v[12:11], 2'd1);
    checkBit("mstatus.MIE", v[3], 1'b0);
    // In M with MIE clear the line is masked
    repeat (2) begin
      retireOne(newEvent(), 12'h080);
      settle(3);
      checkBit("redirectValid", redirectValid, 1'b0);
      expInstret = expInstret + 32'd1;
    end
    csrRd(Minstret, v);
    checkWord("minstret", v, expInstret);
  endtask

  task automatic delegationReturns();
    retireEventT ev;
    redirectT    got;
    wordT        sbase;
    wordT        retPc;
    wordT        ecallPc;
    wordT        v;
    sbase = randWord() & 32'hFFFF_FFC0;
    retPc = randWord() & 32'hFFFF_FFFC;
    csrWr(Mstatus, 32'h0000_0800);
    csrWr(Mepc, retPc);
    csrWr(Medeleg, 32'h0000_0200);
    csrWr(Stvec, sbase);
    ev      = newEvent();
    ev.mret = 1'b1;
    retireOne(ev, '0);
    waitRedirect(got);
    checkRedirect("redirect", got, '{pc: retPc, priv: 2'd1});
    // Ecall from S, delegated through medeleg bit 9
    ev              = newEvent();
    ev.faults.ecall = 1'b1;
    ecallPc         = ev.pc;
    retireOne(ev, '0);
    waitRedirect(got);
    checkRedirect("redirect", got, '{pc: sbase, priv: 2'd1});
    settle(2);
    csrRd(Scause, v);
    checkWord("scause", v, 32'd9);
    csrRd(Sepc, v);
    checkWord("sepc", v, ecallPc);
    csrRd(Stval, v);
    checkWord("stval", v, 32'h0);
    csrRd(Mstatus, v);
    checkBit("mstatus.SPP", v[8], 1'b1);
    // Back to the ecall site in S
    ev      = newEvent();
    ev.sret = 1'b1;
    retireOne(ev, '0);
    waitRedirect(got);
    checkRedirect("redirect", got, '{pc: ecallPc, priv: 2'd1});
    settle(2);
  endtask

  task automatic creditBackPressure();
    retireEventT ev;
    retireEventT sq;
    redirectT    got;
    wordT        vbase;
    wordT        v;
    vbase = randWord() & 32'hFFFF_FFC0;
    csrWr(Mtvec, vbase | 32'h1);
    // Exceptions ignore vectored mode
    ev                     = newEvent();
    ev.faults.illegalInstr = 1'b1;
    retireOne(ev, '0);
    // Later retires would trap if they were not squashed
    for (int i = 0; i < QueueDepth - 1; i++) begin
      sq              = newEvent();
      sq.faults.ecall = 1'b1;
      retireOne(sq, '0);
    end
    checkBit("retireReady", retireReady, 1'b0);
    settle(4);
    checkBit("retireReady", retireReady, 1'b0);
    checkBit("redirectValid", redirectValid, 1'b1);
    waitRedirect(got);
    checkRedirect("redirect", got, '{pc: vbase, priv: 2'd3});
    settle(6);
    checkBit("retireReady", retireReady, 1'b1);
    checkBit("redirectValid", redirectValid, 1'b0);
    csrRd(Minstret, v);
    checkWord("minstret", v, expInstret);
    csrRd(Mcause, v);
    checkWord("mcause", v, 32'd2);
    csrRd(Mepc, v);
    checkWord("mepc", v, ev.pc);
    csrRd(Mtval, v);
    checkWord("mtval", v, ev.instr);
    // Squash is over, next one counts
    retireOne(newEvent(), '0);
    settle(3);
    expInstret = expInstret + 32'd1;
    csrRd(Minstret, v);
    checkWord("minstret", v, expInstret);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(26434));
    reset         = 1'b1;
    retireValid   = 1'b0;
    retire        = '0;
    irqLines      = '0;
    redirectReady = 1'b0;
    csrWrite      = '0;
    csrRdAddr     = '0;
    expInstret    = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    resetState();
    exceptionPriority();
    interruptVectoring();
    delegationReturns();
    creditBackPressure();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
